// File: Bender.yml
package:
  name: eye_tracker

sources:
  - include_dirs:
      - include
    files:
      - hw/eye_tracker_pkg.sv
      - hw/cl_input_sync.sv
      - hw/gravity_accum.sv
      - hw/report_framer.sv
      - hw/uart_tx.sv
      - hw/eye_tracker_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/eye_tracker_props.sv
      - dv/eye_tracker_tb.sv

// File: dv/eye_tracker_props.sv
`timescale 1ns/1ns

`include "eye_tracker_consts.svh"

module eye_tracker_props (
    input logic cclk,
    input logic rst,
    input logic uart_txd,
    input logic tx_busy,
    input logic tx_valid,
    input logic report_trig,
    input logic report_busy
);

    logic [3:0] acc_cnt;            // Bytes taken in the current report
    int         fail_cnt = 0;       // Failed assertions so far

    always_ff @(posedge cclk) begin
        if (rst) begin
            acc_cnt <= '0;
        end else if (report_trig) begin
            acc_cnt <= '0;
        end else if (tx_valid && !tx_busy) begin
            acc_cnt <= acc_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Serial line
    // ----------------------------------------
    idle_high: assert property (@(posedge cclk) disable iff (rst)
        !tx_busy |-> uart_txd)
        else begin
            $error("uart_txd low while the transmitter is idle");
            fail_cnt++;
        end

    // Line high over the whole stop bit
    stop_high: assert property (@(posedge cclk) disable iff (rst)
        $fell(tx_busy) |-> uart_txd && $past(uart_txd, `EYE_BAUD_DIV))
        else begin
            $error("stop bit not high");
            fail_cnt++;
        end

    // ----------------------------------------
    // Report handshake
    // ----------------------------------------
    trig_free: assert property (@(posedge cclk) disable iff (rst)
        report_trig |-> !report_busy)
        else begin
            $error("report_trig while the framer is busy");
            fail_cnt++;
        end

    busy_full: assert property (@(posedge cclk) disable iff (rst)
        $fell(report_busy) |-> acc_cnt == 4'(`EYE_REPORT_BYTES))
        else begin
            $error("report_busy fell before all report bytes were taken");
            fail_cnt++;
        end

endmodule

// File: dv/eye_tracker_tb.sv
`timescale 1ns/1ns

`include "eye_tracker_consts.svh"

module eye_tracker_tb;

    localparam int BIT_T = `EYE_BAUD_DIV;
    localparam int NB    = `EYE_REPORT_BYTES;

    logic cclk, rst, fval, lval, dval, uart_txd;
    eye_tracker_pkg::pix_t data_l, data_r, jp;
    logic [31:0] lfsr = 32'h71e8;
    logic [7:0]  rpt [NB];          // Decoded report
    int errors = 0;
    int tests = 0;
    int bad_tests = 0;

    eye_tracker_top u_eye_tracker_top (.*);

    bind eye_tracker_top eye_tracker_props u_props (
        .cclk(cclk), .rst(rst), .uart_txd(uart_txd), .tx_busy(tx_busy),
        .tx_valid(tx_valid), .report_trig(report_trig), .report_busy(report_busy)
    );

    initial begin
        cclk = 1'b0;
        forever #2 cclk = ~cclk;
    end

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Own checks plus failed bound assertions
    function automatic int error_count();
        return errors + u_eye_tracker_top.u_props.fail_cnt;
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // ----------------------------------------
    // Frame driver with reference model
    // ----------------------------------------
    task automatic drive_frame(input logic [7:0] thr, input int lines, input int pairs,
                               input bit holes, output int s, output int sx, output int sy);
        logic [7:0] v;
        int x, ln, p, dl, dr;
        s  = 0;
        sx = 0;
        sy = 0;
        @(negedge cclk);
        jp   = thr;
        fval = 1'b1;
        for (ln = 0; ln < lines; ln++) begin
            repeat (3) begin            // Gap with data valid but line low
                @(negedge cclk);
                lval = 1'b0;
                dval = 1'b0;
                rand_bits(8, data_l);
                rand_bits(8, data_r);
            end
            x = 0;
            for (p = 0; p < pairs; p++) begin
                @(negedge cclk);
                lval = 1'b1;
                v    = 8'h01;
                if (holes) begin
                    rand_bits(1, v);
                end
                dval = ~v[0];           // Active low
                rand_bits(8, data_l);
                rand_bits(8, data_r);
                dl = v[0] && (data_l < thr);
                dr = v[0] && (data_r < thr);
                s  += dl + dr;
                sx += dl * x + dr * (x + 1);
                sy += (dl + dr) * ln;
                x  += 2 * v[0];
            end
        end
        @(negedge cclk);
        lval = 1'b0;
        dval = 1'b1;
        @(negedge cclk);
        fval = 1'b0;
    endtask

    // ----------------------------------------
    // Serial decoder and checks
    // ----------------------------------------
    task automatic recv_report(output bit ok);
        int i, n, b;
        ok = 1'b1;
        for (i = 0; i < NB && ok; i++) begin
            n = 0;
            while (uart_txd !== 1'b0 && n < (i == 0 ? 16 : 4) * BIT_T) begin
                @(negedge cclk);
                n++;
            end
            ok = (uart_txd === 1'b0);
            repeat (BIT_T / 2) @(negedge cclk);     // Middle of start bit
            for (b = 0; b < 8 && ok; b++) begin
                repeat (BIT_T) @(negedge cclk);
                rpt[i][b] = uart_txd;
            end
            repeat (BIT_T) @(negedge cclk);
        end
        if (!ok) begin
            $display("Timeout at %0t: no start bit seen for a report byte", $time);
            errors++;
        end
    endtask

    task automatic check_report(input int s, input int sx, input int sy);
        logic [NB*8-1:0] want;
        want = {8'(`EYE_REPORT_HDR), 24'(s), 32'(sx), 32'(sy)};
        for (int i = 0; i < NB; i++) begin
            assert (rpt[i] == want[NB*8-1-8*i -: 8]) else begin
                $display("[FAIL] %0t report byte %0d is %h, expected %h",
                         $time, i, rpt[i], want[NB*8-1-8*i -: 8]);
                errors++;
            end
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge cclk);
            assert (uart_txd === 1'b1) else begin
                $display("[FAIL] %0t uart_txd active with no report due", $time);
                errors++;
            end
        end
    endtask

    task automatic frame_and_check(input logic [7:0] thr, input int lines, input int pairs,
                                   input bit holes);
        int s, sx, sy;
        bit ok;
        drive_frame(thr, lines, pairs, holes, s, sx, sy);
        recv_report(ok);
        if (ok) begin
            check_report(s, sx, sy);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (error_count() != err_before) begin
            bad_tests++;
        end
        $display("test %s %s", name, error_count() == err_before ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] seed;
        int e0, s, sx, sy, s2, sx2, sy2;
        bit ok;
        rst    = 1'b1;
        fval   = 1'b0;
        lval   = 1'b0;
        dval   = 1'b1;
        data_l = '0;
        data_r = '0;
        jp     = 8'h40;
        repeat (5) @(posedge cclk);     // Five cycles in reset
        @(negedge cclk);
        rst = 1'b0;

        e0 = error_count();
        check_idle(20 * BIT_T);
        end_test("idle", e0);

        e0   = error_count();
        seed = lfsr;
        frame_and_check(8'h40, 6, 8, 1'b0);
        end_test("single_frame", e0);

        e0   = error_count();
        lfsr = seed;                // Same pixels again
        frame_and_check(8'h00, 6, 8, 1'b0);
        lfsr = seed;
        frame_and_check(8'hFF, 6, 8, 1'b0);
        end_test("threshold", e0);

        e0 = error_count();
        frame_and_check(8'h80, 6, 8, 1'b1);
        end_test("invalid_data", e0);

        // Short frame ends during the first report and is lost
        e0 = error_count();
        drive_frame(8'h40, 4, 8, 1'b0, s, sx, sy);
        fork
            recv_report(ok);
            begin
                repeat (10 * BIT_T) @(negedge cclk);
                drive_frame(8'h40, 1, 2, 1'b0, s2, sx2, sy2);
            end
        join
        if (ok) begin
            check_report(s, sx, sy);
        end
        check_idle(20 * BIT_T);
        frame_and_check(8'h40, 2, 4, 1'b0);
        end_test("back_pressure", e0);

        $display("%0d tests, %0d failed, %0d check errors", tests, bad_tests, error_count());
        if (error_count() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: hw/cl_input_sync.sv
`timescale 1ns/1ns

`include "eye_tracker_consts.svh"

module cl_input_sync (
    input  logic                  cclk,
    input  logic                  rst,
    input  logic                  fval,
    input  logic                  lval,
    input  logic                  dval,
    input  eye_tracker_pkg::pix_t data_l,
    input  eye_tracker_pkg::pix_t data_r,
    output logic                  frame_start,
    output logic                  frame_end,
    output logic                  line_start,
    output logic                  pix_valid,
    output eye_tracker_pkg::pix_t pix_l,
    output eye_tracker_pkg::pix_t pix_r
);

    logic fval_act;
    logic lval_act;
    logic dval_act;
    logic fval_q;                   // Flags seen one cycle earlier
    logic lval_q;

    // Bring every flag to active high
    assign fval_act = (fval == `EYE_FVAL_POL);
    assign lval_act = (lval == `EYE_LVAL_POL);
    assign dval_act = (dval == `EYE_DVAL_POL);

    always_ff @(posedge cclk) begin
        if (rst) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            line_start  <= 1'b0;
            pix_valid   <= 1'b0;
        end else begin
            fval_q      <= fval_act;
            lval_q      <= lval_act;
            frame_start <= fval_act & ~fval_q;
            frame_end   <= ~fval_act & fval_q;
            line_start  <= lval_act & ~lval_q & fval_act;  // Only inside a frame
            pix_valid   <= fval_act & lval_act & dval_act;
        end
    end

    // Pixels ride along with the flags
    always_ff @(posedge cclk) begin
        pix_l <= data_l;
        pix_r <= data_r;
    end

endmodule

// File: hw/eye_tracker_pkg.sv
`include "eye_tracker_consts.svh"

package eye_tracker_pkg;

    // ----------------------------------------
    // Pixel and position
    // ----------------------------------------

    // One tap of the dual tap stream
    typedef logic [`EYE_PIX_W-1:0] pix_t;

    typedef logic [`EYE_COORD_W-1:0] coord_t;    // Column or line index

    // ----------------------------------------
    // Frame sums
    // ----------------------------------------

    // Number of dark pixels in a frame
    typedef logic [`EYE_SUM_S_W-1:0] sum_s_t;

    // Sum of x or of y over the dark pixels
    typedef logic [`EYE_SUM_XY_W-1:0] sum_xy_t;

endpackage

// File: hw/eye_tracker_top.sv
`timescale 1ns/1ns

module eye_tracker_top (
    input  logic                  cclk,
    input  logic                  rst,
    input  logic                  fval,
    input  logic                  lval,
    input  logic                  dval,
    input  eye_tracker_pkg::pix_t data_l,
    input  eye_tracker_pkg::pix_t data_r,
    input  eye_tracker_pkg::pix_t jp,
    output logic                  uart_txd
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------
    logic                     frame_start;
    logic                     frame_end;
    logic                     line_start;
    logic                     pix_valid;
    eye_tracker_pkg::pix_t    pix_l;
    eye_tracker_pkg::pix_t    pix_r;

    logic                     report_trig;
    logic                     report_busy;
    eye_tracker_pkg::sum_s_t  sum_s;
    eye_tracker_pkg::sum_xy_t sum_x;
    eye_tracker_pkg::sum_xy_t sum_y;

    logic                     tx_valid;
    logic                     tx_busy;
    eye_tracker_pkg::pix_t    tx_data;

    // Camera in
    cl_input_sync u_cl_input_sync (
        .cclk(cclk), .rst(rst), .fval(fval), .lval(lval), .dval(dval),
        .data_l(data_l), .data_r(data_r),
        .frame_start(frame_start), .frame_end(frame_end), .line_start(line_start),
        .pix_valid(pix_valid), .pix_l(pix_l), .pix_r(pix_r)
    );

    // Pupil centroid sums
    gravity_accum u_gravity_accum (
        .cclk(cclk), .rst(rst), .frame_start(frame_start), .frame_end(frame_end),
        .line_start(line_start), .pix_valid(pix_valid), .pix_l(pix_l), .pix_r(pix_r),
        .jp(jp), .report_busy(report_busy), .report_trig(report_trig),
        .sum_s(sum_s), .sum_x(sum_x), .sum_y(sum_y)
    );

    report_framer u_report_framer (
        .cclk(cclk), .rst(rst), .report_trig(report_trig),
        .sum_s(sum_s), .sum_x(sum_x), .sum_y(sum_y), .report_busy(report_busy),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_busy(tx_busy)
    );

    uart_tx u_uart_tx (
        .cclk(cclk), .rst(rst), .tx_valid(tx_valid), .tx_data(tx_data),
        .tx_busy(tx_busy), .uart_txd(uart_txd)
    );

endmodule

// File: hw/gravity_accum.sv
`timescale 1ns/1ns

module gravity_accum (
    input  logic                     cclk,
    input  logic                     rst,
    input  logic                     frame_start,
    input  logic                     frame_end,
    input  logic                     line_start,
    input  logic                     pix_valid,
    input  eye_tracker_pkg::pix_t    pix_l,
    input  eye_tracker_pkg::pix_t    pix_r,
    input  eye_tracker_pkg::pix_t    jp,           // Threshold
    input  logic                     report_busy,
    output logic                     report_trig,
    output eye_tracker_pkg::sum_s_t  sum_s,
    output eye_tracker_pkg::sum_xy_t sum_x,
    output eye_tracker_pkg::sum_xy_t sum_y
);

    eye_tracker_pkg::coord_t  x_cnt;
    eye_tracker_pkg::coord_t  y_cnt;
    eye_tracker_pkg::coord_t  x_cur;
    eye_tracker_pkg::coord_t  y_cur;
    eye_tracker_pkg::coord_t  y_base;
    eye_tracker_pkg::sum_s_t  acc_s;
    eye_tracker_pkg::sum_s_t  inc_s;
    eye_tracker_pkg::sum_xy_t acc_x;
    eye_tracker_pkg::sum_xy_t inc_x;
    eye_tracker_pkg::sum_xy_t acc_y;
    eye_tracker_pkg::sum_xy_t inc_y;
    eye_tracker_pkg::sum_xy_t x_ext;
    eye_tracker_pkg::sum_xy_t y_ext;
    logic                     dark_l;
    logic                     dark_r;
    logic                     hand_off;

    // ----------------------------------------
    // Coordinates of the current pair
    // ----------------------------------------
    // Both also hold when a frame or line starts in this very cycle
    assign y_base = frame_start ? '1 : y_cnt;             // All ones wraps to line 0
    assign y_cur  = line_start ? y_base + 1'b1 : y_base;
    assign x_cur  = line_start ? '0 : x_cnt;

    // Strictly darker than the threshold
    assign dark_l = pix_valid & (pix_l < jp);
    assign dark_r = pix_valid & (pix_r < jp);

    assign x_ext = eye_tracker_pkg::sum_xy_t'(x_cur);
    assign y_ext = eye_tracker_pkg::sum_xy_t'(y_cur);

    assign inc_s = eye_tracker_pkg::sum_s_t'(dark_l) + eye_tracker_pkg::sum_s_t'(dark_r);
    assign inc_x = (dark_l ? x_ext : '0) + (dark_r ? x_ext + 1'b1 : '0);  // Right tap at x+1
    assign inc_y = (dark_l ? y_ext : '0) + (dark_r ? y_ext : '0);

    // ----------------------------------------
    // Counters and running sums
    // ----------------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
            acc_s <= '0;
            acc_x <= '0;
            acc_y <= '0;
        end else begin
            y_cnt <= y_cur;
            x_cnt <= pix_valid ? x_cur + 2'd2 : x_cur;
            acc_s <= (frame_start ? '0 : acc_s) + inc_s;  // Cleared at frame start
            acc_x <= (frame_start ? '0 : acc_x) + inc_x;
            acc_y <= (frame_start ? '0 : acc_y) + inc_y;
        end
    end

    // ----------------------------------------
    // Hand off at frame end
    // ----------------------------------------
    // A busy framer means this frame is lost
    assign hand_off = frame_end & ~report_busy;

    always_ff @(posedge cclk) begin
        if (rst) begin
            report_trig <= 1'b0;
        end else begin
            report_trig <= hand_off;
        end
    end

    always_ff @(posedge cclk) begin
        if (hand_off) begin
            sum_s <= acc_s;
            sum_x <= acc_x;
            sum_y <= acc_y;
        end
    end

endmodule

// File: hw/report_framer.sv
`timescale 1ns/1ns

`include "eye_tracker_consts.svh"

module report_framer (
    input  logic                     cclk,
    input  logic                     rst,
    input  logic                     report_trig,
    input  eye_tracker_pkg::sum_s_t  sum_s,
    input  eye_tracker_pkg::sum_xy_t sum_x,
    input  eye_tracker_pkg::sum_xy_t sum_y,
    output logic                     report_busy,
    output logic                     tx_valid,
    output eye_tracker_pkg::pix_t    tx_data,
    input  logic                     tx_busy
);

    localparam int NBYTES = `EYE_REPORT_BYTES;
    localparam int SR_W   = NBYTES * 8;
    localparam int CNT_W  = $clog2(NBYTES);

    logic [SR_W-1:0]  shreg;        // Next byte sits at the top
    logic [CNT_W-1:0] byte_cnt;
    logic             accept;
    logic             load;

    assign load     = report_trig & ~report_busy;
    assign accept   = tx_valid & ~tx_busy;
    assign tx_valid = report_busy;                 // A byte is pending for the whole report
    assign tx_data  = shreg[SR_W-1 -: 8];

    // ----------------------------------------
    // Byte counter
    // ----------------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            report_busy <= 1'b0;
            byte_cnt    <= '0;
        end else if (!report_busy) begin
            if (report_trig) begin
                report_busy <= 1'b1;
                byte_cnt    <= '0;
            end
        end else if (accept) begin
            if (byte_cnt == CNT_W'(NBYTES - 1)) begin
                report_busy <= 1'b0;               // Last byte taken
            end
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Report shift register
    // ----------------------------------------
    // Header, count in 3 bytes, x and y in 4 bytes each, MSB first
    always_ff @(posedge cclk) begin
        if (load) begin
            shreg <= {`EYE_REPORT_HDR, 24'(sum_s), 32'(sum_x), 32'(sum_y)};
        end else if (accept) begin
            shreg <= {shreg[SR_W-9:0], 8'h00};
        end
    end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns

`include "eye_tracker_consts.svh"

module uart_tx #(
    parameter int BAUD_DIV = `EYE_BAUD_DIV        // cclk cycles per bit
) (
    input  logic                  cclk,
    input  logic                  rst,
    input  logic                  tx_valid,
    input  eye_tracker_pkg::pix_t tx_data,
    output logic                  tx_busy,
    output logic                  uart_txd
);

    localparam int CNT_W = $clog2(BAUD_DIV + 1);

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;      // 0 start, 1..8 data, 9 stop
    logic [8:0]       shreg;        // Data bits then stop bit
    logic             bit_done;

    assign bit_done = (baud_cnt == CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge cclk) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            uart_txd <= 1'b1;       // Idle line
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (!tx_busy) begin
            if (tx_valid) begin
                tx_busy  <= 1'b1;
                uart_txd <= 1'b0;   // Start bit
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end else if (bit_done) begin
            baud_cnt <= '0;
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;    // Stop bit done, line stays high
            end else begin
                uart_txd <= shreg[0];
                bit_idx  <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // LSB first
    always_ff @(posedge cclk) begin
        if (!tx_busy && tx_valid) begin
            shreg <= {1'b1, tx_data};
        end else if (tx_busy && bit_done) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

// File: include/eye_tracker_consts.svh
`ifndef EYE_TRACKER_CONSTS_SVH
`define EYE_TRACKER_CONSTS_SVH

// ----------------------------------------
// Data path widths
// ----------------------------------------
`define EYE_PIX_W        8          // One camera tap
`define EYE_COORD_W      10         // 640 columns, 480 lines
`define EYE_SUM_S_W      20         // Dark pixel count
`define EYE_SUM_XY_W     28         // Coordinate sums

// ----------------------------------------
// Camera flag levels
// ----------------------------------------
`define EYE_FVAL_POL     1'b1
`define EYE_LVAL_POL     1'b1
`define EYE_DVAL_POL     1'b0       // Data valid is active low

// ----------------------------------------
// Serial report
// ----------------------------------------
`define EYE_REPORT_HDR   8'hA5
`define EYE_REPORT_BYTES 12
`define EYE_BAUD_DIV     16         // cclk cycles per bit

`endif

// File: list.f
+incdir+include
hw/eye_tracker_pkg.sv
hw/cl_input_sync.sv
hw/gravity_accum.sv
hw/report_framer.sv
hw/uart_tx.sv
hw/eye_tracker_top.sv
dv/eye_tracker_props.sv
dv/eye_tracker_tb.sv
